// ==== common/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] alu_op_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // primary opcode field, inst[31:26]
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0a;
    localparam opcode_t OP_SLTIU   = 6'h0b;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_XORI    = 6'h0e;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;

    // function field of SPECIAL, inst[5:0]
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_SRA  = 6'h03;
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_SLT  = 6'h2a;
    localparam funct_t FN_SLTU = 6'h2b;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;

    // bit positions in the one-hot alu_op vector
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    // link register for jal
    localparam reg_addr_t REG_RA = 5'd31;

endpackage

`default_nettype wire

// ==== hdl/regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module regfile (
    input  wire                        clk,
    input  wire decode_pkg::reg_addr_t raddr1,
    input  wire decode_pkg::reg_addr_t raddr2,
    input  wire                        we,
    input  wire decode_pkg::reg_addr_t waddr,
    input  wire decode_pkg::word_t     wdata,
    output decode_pkg::word_t          rdata1,
    output decode_pkg::word_t          rdata2
);

    decode_pkg::word_t mem [32];

    // r0 is never stored, reads below force it to zero
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : mem[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : mem[raddr2];

endmodule

`default_nettype wire

// ==== hdl/operand_forward.sv ====
`timescale 1ns/1ns
`default_nettype none

module operand_forward (
    input  wire decode_pkg::reg_addr_t rs,
    input  wire decode_pkg::reg_addr_t rt,
    input  wire decode_pkg::word_t     rf_rs,
    input  wire decode_pkg::word_t     rf_rt,
    input  wire                        es_valid,
    input  wire                        es_gr_we,
    input  wire                        es_load,
    input  wire decode_pkg::reg_addr_t es_dest,
    input  wire decode_pkg::word_t     es_value,
    input  wire                        ms_valid,
    input  wire                        ms_gr_we,
    input  wire decode_pkg::reg_addr_t ms_dest,
    input  wire decode_pkg::word_t     ms_value,
    input  wire                        ws_valid,
    input  wire                        ws_gr_we,
    input  wire decode_pkg::reg_addr_t ws_dest,
    input  wire decode_pkg::word_t     ws_value,
    output decode_pkg::word_t          rs_value,
    output decode_pkg::word_t          rt_value
);

    // a load in execute has no data yet, the interlock covers that case
    function automatic decode_pkg::word_t pick(input decode_pkg::reg_addr_t src,
                                               input decode_pkg::word_t rf_value);
        if (src == '0)
            return '0;
        else if (es_valid && es_gr_we && !es_load && es_dest == src)
            return es_value;
        else if (ms_valid && ms_gr_we && ms_dest == src)
            return ms_value;
        else if (ws_valid && ws_gr_we && ws_dest == src)
            return ws_value;
        else
            return rf_value;
    endfunction

    assign rs_value = pick(rs, rf_rs);
    assign rt_value = pick(rt, rf_rt);

    // known stage inputs and regfile data must give known operands
    always_comb begin
        if (!$isunknown({rs, rt, rf_rs, rf_rt, es_valid, es_gr_we, es_load, es_dest,
                         es_value, ms_valid, ms_gr_we, ms_dest, ms_value,
                         ws_valid, ws_gr_we, ws_dest, ws_value})) begin
            a_fwd_known : assert final (!$isunknown({rs_value, rt_value}));
        end
    end

endmodule

`default_nettype wire

// ==== hdl/stage_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module stage_control (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        fs_valid,
    input  wire decode_pkg::inst_t     fs_inst,
    input  wire decode_pkg::word_t     fs_pc,
    input  wire                        es_allowin,
    input  wire                        es_valid,
    input  wire                        es_load,
    input  wire decode_pkg::reg_addr_t es_dest,
    input  wire                        ms_valid,
    input  wire                        ms_load,
    input  wire decode_pkg::reg_addr_t ms_dest,
    output logic                       ds_allowin,
    output logic                       ds_to_es_valid,
    output decode_pkg::inst_t          inst,
    output decode_pkg::word_t          pc
);

    logic                  ds_valid;
    logic                  ready;
    logic                  es_hit;
    logic                  ms_hit;
    decode_pkg::reg_addr_t rs;
    decode_pkg::reg_addr_t rt;

    assign rs = inst[25:21];
    assign rt = inst[20:16];

    // load-use hazard against execute or memory
    assign es_hit = es_valid && es_load &&
                    ((rs != '0 && rs == es_dest) || (rt != '0 && rt == es_dest));
    assign ms_hit = ms_valid && ms_load &&
                    ((rs != '0 && rs == ms_dest) || (rt != '0 && rt == ms_dest));
    assign ready  = !(es_hit || ms_hit);

    assign ds_allowin     = !ds_valid || (ready && es_allowin);
    assign ds_to_es_valid = ds_valid && ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (fs_valid && ds_allowin) begin
            ds_valid <= 1'b1;
        end else if (ready && es_allowin) begin
            ds_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            inst <= fs_inst;
            pc   <= fs_pc;
        end
    end

    // an instruction that leaves with nothing behind it empties the slot
    a_leave_clears : assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && es_allowin && !fs_valid |=> !ds_valid);

    // a stalled slot keeps its instruction
    a_hold_inst : assert property (@(posedge clk) disable iff (reset)
        ds_valid && !es_allowin |=> $stable(inst));

endmodule

`default_nettype wire

// ==== decode/inst_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
    input  wire decode_pkg::inst_t     inst,
    output decode_pkg::alu_op_t        alu_op,
    output logic                       src1_is_sa,
    output logic                       src1_is_pc,
    output logic                       src2_is_imm,
    output logic                       src2_is_8,
    output logic                       zero_ext_imm,
    output logic                       load,
    output logic                       mem_we,
    output logic                       gr_we,
    output decode_pkg::reg_addr_t      dest,
    output logic [15:0]                imm,
    output logic                       is_branch,
    output logic                       is_jump_reg,
    output logic                       is_jump_imm,
    output logic [1:0]                 br_cond
);

    decode_pkg::opcode_t   op;
    decode_pkg::funct_t    fn;
    decode_pkg::reg_addr_t rs;
    decode_pkg::reg_addr_t rt;
    decode_pkg::reg_addr_t rd;
    logic [4:0]            sa;
    logic                  special;
    logic inst_addu, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra, inst_jr;
    logic inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori;
    logic inst_lui, inst_lw, inst_sw, inst_beq, inst_bne, inst_j, inst_jal;
    logic dst_is_rt;

    assign op  = inst[31:26];
    assign rs  = inst[25:21];
    assign rt  = inst[20:16];
    assign rd  = inst[15:11];
    assign sa  = inst[10:6];
    assign fn  = inst[5:0];
    assign imm = inst[15:0];

    assign special = (op == decode_pkg::OP_SPECIAL);

    // R-type: unused fields must be zero or the word is not recognised
    assign inst_addu = special && fn == decode_pkg::FN_ADDU && sa == '0;
    assign inst_subu = special && fn == decode_pkg::FN_SUBU && sa == '0;
    assign inst_slt  = special && fn == decode_pkg::FN_SLT  && sa == '0;
    assign inst_sltu = special && fn == decode_pkg::FN_SLTU && sa == '0;
    assign inst_and  = special && fn == decode_pkg::FN_AND  && sa == '0;
    assign inst_or   = special && fn == decode_pkg::FN_OR   && sa == '0;
    assign inst_xor  = special && fn == decode_pkg::FN_XOR  && sa == '0;
    assign inst_nor  = special && fn == decode_pkg::FN_NOR  && sa == '0;
    assign inst_sll  = special && fn == decode_pkg::FN_SLL  && rs == '0;
    assign inst_srl  = special && fn == decode_pkg::FN_SRL  && rs == '0;
    assign inst_sra  = special && fn == decode_pkg::FN_SRA  && rs == '0;
    assign inst_jr   = special && fn == decode_pkg::FN_JR   && inst[20:6] == '0;

    assign inst_addiu = (op == decode_pkg::OP_ADDIU);
    assign inst_slti  = (op == decode_pkg::OP_SLTI);
    assign inst_sltiu = (op == decode_pkg::OP_SLTIU);
    assign inst_andi  = (op == decode_pkg::OP_ANDI);
    assign inst_ori   = (op == decode_pkg::OP_ORI);
    assign inst_xori  = (op == decode_pkg::OP_XORI);
    assign inst_lui   = (op == decode_pkg::OP_LUI) && rs == '0;
    assign inst_lw    = (op == decode_pkg::OP_LW);
    assign inst_sw    = (op == decode_pkg::OP_SW);
    assign inst_beq   = (op == decode_pkg::OP_BEQ);
    assign inst_bne   = (op == decode_pkg::OP_BNE);
    assign inst_j     = (op == decode_pkg::OP_J);
    assign inst_jal   = (op == decode_pkg::OP_JAL);

    assign alu_op[decode_pkg::ALU_ADD]  = inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal;
    assign alu_op[decode_pkg::ALU_SUB]  = inst_subu;
    assign alu_op[decode_pkg::ALU_SLT]  = inst_slt  | inst_slti;
    assign alu_op[decode_pkg::ALU_SLTU] = inst_sltu | inst_sltiu;
    assign alu_op[decode_pkg::ALU_AND]  = inst_and  | inst_andi;
    assign alu_op[decode_pkg::ALU_NOR]  = inst_nor;
    assign alu_op[decode_pkg::ALU_OR]   = inst_or   | inst_ori;
    assign alu_op[decode_pkg::ALU_XOR]  = inst_xor  | inst_xori;
    assign alu_op[decode_pkg::ALU_SLL]  = inst_sll;
    assign alu_op[decode_pkg::ALU_SRL]  = inst_srl;
    assign alu_op[decode_pkg::ALU_SRA]  = inst_sra;
    assign alu_op[decode_pkg::ALU_LUI]  = inst_lui;

    assign src1_is_sa   = inst_sll | inst_srl | inst_sra;
    // jal computes pc + 8 as its link value
    assign src1_is_pc   = inst_jal;
    assign src2_is_8    = inst_jal;
    assign src2_is_imm  = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori
                        | inst_xori  | inst_lui  | inst_lw    | inst_sw;
    assign zero_ext_imm = inst_andi | inst_ori | inst_xori;
    assign load         = inst_lw;
    assign mem_we       = inst_sw;

    assign dst_is_rt = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori
                     | inst_xori  | inst_lui  | inst_lw;
    assign gr_we     = dst_is_rt | inst_jal | (|alu_op[decode_pkg::ALU_SRA:decode_pkg::ALU_SUB])
                     | inst_addu;
    assign dest      = inst_jal  ? decode_pkg::REG_RA :
                       dst_is_rt ? rt : rd;

    // br_cond is one-hot, bit 0 for beq and bit 1 for bne
    assign is_branch   = inst_beq | inst_bne;
    assign br_cond     = {inst_bne, inst_beq};
    assign is_jump_reg = inst_jr;
    assign is_jump_imm = inst_j | inst_jal;

    always_comb begin
        a_alu_onehot : assert final ($onehot0(alu_op));
    end

endmodule

`default_nettype wire

// ==== decode/branch_resolve.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_resolve (
    input  wire                    valid,
    input  wire decode_pkg::word_t pc,
    input  wire [15:0]             imm,
    input  wire [25:0]             jidx,
    input  wire                    is_branch,
    input  wire                    is_jump_reg,
    input  wire                    is_jump_imm,
    input  wire [1:0]              br_cond,
    input  wire decode_pkg::word_t rs_value,
    input  wire decode_pkg::word_t rt_value,
    output logic                   br_taken,
    output decode_pkg::word_t      br_target
);

    decode_pkg::word_t pc_plus4;
    decode_pkg::word_t br_offset;
    logic              rs_eq_rt;
    logic              cond_met;

    assign pc_plus4  = pc + 32'd4;
    assign br_offset = {{14{imm[15]}}, imm, 2'b00};
    assign rs_eq_rt  = (rs_value == rt_value);

    assign cond_met = (br_cond[0] && rs_eq_rt) || (br_cond[1] && !rs_eq_rt);

    // only a slot that is leaving this cycle may redirect fetch
    assign br_taken = valid && ((is_branch && cond_met) || is_jump_reg || is_jump_imm);

    assign br_target = is_branch   ? pc_plus4 + br_offset :
                       is_jump_reg ? rs_value :
                                     {pc_plus4[31:28], jidx, 2'b00};

endmodule

`default_nettype wire

// ==== hdl/id_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module id_stage (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        fs_valid,
    input  wire decode_pkg::inst_t     fs_inst,
    input  wire decode_pkg::word_t     fs_pc,
    output logic                       ds_allowin,
    input  wire                        es_allowin,
    input  wire                        es_valid,
    input  wire                        es_gr_we,
    input  wire                        es_load,
    input  wire decode_pkg::reg_addr_t es_dest,
    input  wire decode_pkg::word_t     es_value,
    input  wire                        ms_valid,
    input  wire                        ms_gr_we,
    input  wire                        ms_load,
    input  wire decode_pkg::reg_addr_t ms_dest,
    input  wire decode_pkg::word_t     ms_value,
    input  wire                        ws_valid,
    input  wire                        ws_gr_we,
    input  wire decode_pkg::reg_addr_t ws_dest,
    input  wire decode_pkg::word_t     ws_value,
    output logic                       ds_to_es_valid,
    output decode_pkg::word_t          ds_pc,
    output decode_pkg::alu_op_t        ds_alu_op,
    output logic                       ds_src1_is_sa,
    output logic                       ds_src1_is_pc,
    output logic                       ds_src2_is_imm,
    output logic                       ds_src2_is_8,
    output logic                       ds_zero_ext_imm,
    output logic                       ds_load,
    output logic                       ds_mem_we,
    output logic                       ds_gr_we,
    output decode_pkg::reg_addr_t      ds_dest,
    output logic [15:0]                ds_imm,
    output decode_pkg::word_t          ds_rs_value,
    output decode_pkg::word_t          ds_rt_value,
    output logic                       br_taken,
    output decode_pkg::word_t          br_target
);

    decode_pkg::inst_t ds_inst;
    decode_pkg::word_t rf_rdata1;
    decode_pkg::word_t rf_rdata2;
    logic              is_branch;
    logic              is_jump_reg;
    logic              is_jump_imm;
    logic [1:0]        br_cond;

    stage_control stage_control_i (
        .clk(clk), .reset(reset),
        .fs_valid(fs_valid), .fs_inst(fs_inst), .fs_pc(fs_pc),
        .es_allowin(es_allowin),
        .es_valid(es_valid), .es_load(es_load), .es_dest(es_dest),
        .ms_valid(ms_valid), .ms_load(ms_load), .ms_dest(ms_dest),
        .ds_allowin(ds_allowin), .ds_to_es_valid(ds_to_es_valid),
        .inst(ds_inst), .pc(ds_pc)
    );

    inst_decoder inst_decoder_i (
        .inst(ds_inst), .alu_op(ds_alu_op),
        .src1_is_sa(ds_src1_is_sa), .src1_is_pc(ds_src1_is_pc),
        .src2_is_imm(ds_src2_is_imm), .src2_is_8(ds_src2_is_8),
        .zero_ext_imm(ds_zero_ext_imm), .load(ds_load), .mem_we(ds_mem_we),
        .gr_we(ds_gr_we), .dest(ds_dest), .imm(ds_imm),
        .is_branch(is_branch), .is_jump_reg(is_jump_reg),
        .is_jump_imm(is_jump_imm), .br_cond(br_cond)
    );

    // writeback owns the write port
    regfile regfile_i (
        .clk(clk), .raddr1(ds_inst[25:21]), .raddr2(ds_inst[20:16]),
        .we(ws_valid & ws_gr_we), .waddr(ws_dest), .wdata(ws_value),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2)
    );

    operand_forward operand_forward_i (
        .rs(ds_inst[25:21]), .rt(ds_inst[20:16]),
        .rf_rs(rf_rdata1), .rf_rt(rf_rdata2),
        .es_valid(es_valid), .es_gr_we(es_gr_we), .es_load(es_load),
        .es_dest(es_dest), .es_value(es_value),
        .ms_valid(ms_valid), .ms_gr_we(ms_gr_we), .ms_dest(ms_dest), .ms_value(ms_value),
        .ws_valid(ws_valid), .ws_gr_we(ws_gr_we), .ws_dest(ws_dest), .ws_value(ws_value),
        .rs_value(ds_rs_value), .rt_value(ds_rt_value)
    );

    branch_resolve branch_resolve_i (
        .valid(ds_to_es_valid), .pc(ds_pc), .imm(ds_imm), .jidx(ds_inst[25:0]),
        .is_branch(is_branch), .is_jump_reg(is_jump_reg), .is_jump_imm(is_jump_imm),
        .br_cond(br_cond), .rs_value(ds_rs_value), .rt_value(ds_rt_value),
        .br_taken(br_taken), .br_target(br_target)
    );

endmodule

`default_nettype wire

// ==== sim/id_ref_model.svh ====
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// expected controls for one instruction word
typedef struct packed {
    decode_pkg::alu_op_t   alu_op;
    // src1_is_sa, src1_is_pc, src2_is_imm, src2_is_8, zero_ext_imm, load, mem_we, gr_we
    logic [7:0]            flags;
    decode_pkg::reg_addr_t dest;
    logic                  is_branch;
    logic                  is_jump_reg;
    logic                  is_jump_imm;
    logic [1:0]            br_cond;
} ctl_t;

// shadow copy of the register file, written from the writeback inputs
decode_pkg::word_t shadow_rf [32];

function automatic ctl_t expected_ctl(input decode_pkg::inst_t inst);
    ctl_t                c;
    decode_pkg::opcode_t op;
    decode_pkg::funct_t  fn;
    int                  pos;
    logic                imm_op;
    op  = inst[31:26];
    fn  = inst[5:0];
    pos = -1;
    c   = '0;
    case (op)
        decode_pkg::OP_SPECIAL: begin
            c.is_jump_reg = (fn == decode_pkg::FN_JR) && (inst[20:6] == '0);
            // shifts need rs zero, the others need sa zero
            if (inst[25:21] == '0) begin
                case (fn)
                    decode_pkg::FN_SLL: pos = decode_pkg::ALU_SLL;
                    decode_pkg::FN_SRL: pos = decode_pkg::ALU_SRL;
                    decode_pkg::FN_SRA: pos = decode_pkg::ALU_SRA;
                    default: ;
                endcase
            end
            if (inst[10:6] == '0) begin
                case (fn)
                    decode_pkg::FN_ADDU: pos = decode_pkg::ALU_ADD;
                    decode_pkg::FN_SUBU: pos = decode_pkg::ALU_SUB;
                    decode_pkg::FN_SLT:  pos = decode_pkg::ALU_SLT;
                    decode_pkg::FN_SLTU: pos = decode_pkg::ALU_SLTU;
                    decode_pkg::FN_AND:  pos = decode_pkg::ALU_AND;
                    decode_pkg::FN_OR:   pos = decode_pkg::ALU_OR;
                    decode_pkg::FN_XOR:  pos = decode_pkg::ALU_XOR;
                    decode_pkg::FN_NOR:  pos = decode_pkg::ALU_NOR;
                    default: ;
                endcase
            end
        end
        decode_pkg::OP_ADDIU, decode_pkg::OP_LW, decode_pkg::OP_SW, decode_pkg::OP_JAL:
            pos = decode_pkg::ALU_ADD;
        decode_pkg::OP_SLTI:  pos = decode_pkg::ALU_SLT;
        decode_pkg::OP_SLTIU: pos = decode_pkg::ALU_SLTU;
        decode_pkg::OP_ANDI:  pos = decode_pkg::ALU_AND;
        decode_pkg::OP_ORI:   pos = decode_pkg::ALU_OR;
        decode_pkg::OP_XORI:  pos = decode_pkg::ALU_XOR;
        decode_pkg::OP_LUI:   pos = (inst[25:21] == '0) ? decode_pkg::ALU_LUI : -1;
        default: ;
    endcase
    if (pos >= 0)
        c.alu_op[pos] = 1'b1;
    imm_op  = (pos >= 0) && (op != decode_pkg::OP_SPECIAL) && (op != decode_pkg::OP_JAL);
    c.flags = {pos inside {decode_pkg::ALU_SLL, decode_pkg::ALU_SRL, decode_pkg::ALU_SRA},
               op == decode_pkg::OP_JAL, imm_op, op == decode_pkg::OP_JAL,
               op inside {decode_pkg::OP_ANDI, decode_pkg::OP_ORI, decode_pkg::OP_XORI},
               op == decode_pkg::OP_LW, op == decode_pkg::OP_SW,
               (pos >= 0) && (op != decode_pkg::OP_SW)};
    c.dest  = (op == decode_pkg::OP_JAL) ? decode_pkg::REG_RA :
              (imm_op && op != decode_pkg::OP_SW) ? inst[20:16] : inst[15:11];
    c.is_branch   = op inside {decode_pkg::OP_BEQ, decode_pkg::OP_BNE};
    c.br_cond     = {op == decode_pkg::OP_BNE, op == decode_pkg::OP_BEQ};
    c.is_jump_imm = op inside {decode_pkg::OP_J, decode_pkg::OP_JAL};
    return c;
endfunction

// nearest producer wins, a load in execute has no value to give
function automatic decode_pkg::word_t forwarded_value(input decode_pkg::reg_addr_t src);
    if (src == '0)
        return '0;
    if (es_valid && es_gr_we && !es_load && es_dest == src)
        return es_value;
    if (ms_valid && ms_gr_we && ms_dest == src)
        return ms_value;
    if (ws_valid && ws_gr_we && ws_dest == src)
        return ws_value;
    return shadow_rf[src];
endfunction

function automatic logic load_use_hazard(input decode_pkg::inst_t inst);
    logic es_match;
    logic ms_match;
    es_match = es_dest != '0 && (es_dest == inst[25:21] || es_dest == inst[20:16]);
    ms_match = ms_dest != '0 && (ms_dest == inst[25:21] || ms_dest == inst[20:16]);
    return (es_valid && es_load && es_match) || (ms_valid && ms_load && ms_match);
endfunction

function automatic logic resolve_taken(input ctl_t c, input decode_pkg::word_t a,
                                       input decode_pkg::word_t b);
    return c.is_jump_reg || c.is_jump_imm || (c.br_cond[0] && a == b) || (c.br_cond[1] && a != b);
endfunction

function automatic decode_pkg::word_t jump_target(input ctl_t c, input decode_pkg::inst_t inst,
                                                  input decode_pkg::word_t pc,
                                                  input decode_pkg::word_t a);
    decode_pkg::word_t seq;
    seq = pc + 32'd4;
    if (c.is_branch)
        return seq + ({{16{inst[15]}}, inst[15:0]} << 2);
    if (c.is_jump_reg)
        return a;
    return {seq[31:28], inst[25:0], 2'b00};
endfunction

`endif

// ==== sim/tb_id_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_id_stage;

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_CYCLES  = 3000;
    localparam int DRAIN_LIMIT = 16;

    // field tables for the random instruction mix, six bits per entry
    localparam logic [47:0] ARITH_FN = {decode_pkg::FN_ADDU, decode_pkg::FN_SUBU,
        decode_pkg::FN_SLT, decode_pkg::FN_SLTU, decode_pkg::FN_AND, decode_pkg::FN_OR,
        decode_pkg::FN_XOR, decode_pkg::FN_NOR};
    localparam logic [17:0] SHIFT_FN = {decode_pkg::FN_SLL, decode_pkg::FN_SRL, decode_pkg::FN_SRA};
    localparam logic [59:0] IMM_OP = {decode_pkg::OP_ADDIU, decode_pkg::OP_SLTI,
        decode_pkg::OP_SLTIU, decode_pkg::OP_ANDI, decode_pkg::OP_ORI, decode_pkg::OP_XORI,
        decode_pkg::OP_LW, decode_pkg::OP_SW, decode_pkg::OP_BEQ, decode_pkg::OP_BNE};

    logic clk, reset, fs_valid, ds_allowin, es_allowin, ds_to_es_valid, br_taken;
    logic es_valid, es_gr_we, es_load, ms_valid, ms_gr_we, ms_load, ws_valid, ws_gr_we;
    logic ds_src1_is_sa, ds_src1_is_pc, ds_src2_is_imm, ds_src2_is_8;
    logic ds_zero_ext_imm, ds_load, ds_mem_we, ds_gr_we;
    logic [15:0] ds_imm;
    decode_pkg::inst_t fs_inst;
    decode_pkg::alu_op_t ds_alu_op;
    decode_pkg::reg_addr_t es_dest, ms_dest, ws_dest, ds_dest;
    decode_pkg::word_t fs_pc, es_value, ms_value, ws_value;
    decode_pkg::word_t ds_pc, ds_rs_value, ds_rt_value, br_target;

    // model of the slot contents and of pcs sent but not yet accepted
    logic slot_valid;
    decode_pkg::inst_t slot_inst;
    decode_pkg::word_t slot_pc, next_pc;
    decode_pkg::word_t pc_queue [$];
    int errors, checks;

    `include "id_ref_model.svh"

    id_stage id_stage_i (
        .clk(clk), .reset(reset), .fs_valid(fs_valid), .fs_inst(fs_inst), .fs_pc(fs_pc),
        .ds_allowin(ds_allowin), .es_allowin(es_allowin),
        .es_valid(es_valid), .es_gr_we(es_gr_we), .es_load(es_load),
        .es_dest(es_dest), .es_value(es_value),
        .ms_valid(ms_valid), .ms_gr_we(ms_gr_we), .ms_load(ms_load),
        .ms_dest(ms_dest), .ms_value(ms_value),
        .ws_valid(ws_valid), .ws_gr_we(ws_gr_we), .ws_dest(ws_dest), .ws_value(ws_value),
        .ds_to_es_valid(ds_to_es_valid), .ds_pc(ds_pc), .ds_alu_op(ds_alu_op),
        .ds_src1_is_sa(ds_src1_is_sa), .ds_src1_is_pc(ds_src1_is_pc),
        .ds_src2_is_imm(ds_src2_is_imm), .ds_src2_is_8(ds_src2_is_8),
        .ds_zero_ext_imm(ds_zero_ext_imm), .ds_load(ds_load), .ds_mem_we(ds_mem_we),
        .ds_gr_we(ds_gr_we), .ds_dest(ds_dest), .ds_imm(ds_imm),
        .ds_rs_value(ds_rs_value), .ds_rt_value(ds_rt_value),
        .br_taken(br_taken), .br_target(br_target)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("ERROR: %s at %0t", what, $time);
    endtask

    // mostly the kept subset with small register numbers, some raw words
    function automatic decode_pkg::inst_t random_inst();
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        int         kind;
        rs   = 5'($urandom % 8);
        rt   = 5'($urandom % 8);
        rd   = 5'($urandom % 8);
        kind = int'($urandom % 28);
        if (kind < 8)
            return {decode_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, ARITH_FN[kind*6 +: 6]};
        else if (kind < 11)
            return {decode_pkg::OP_SPECIAL, 5'd0, rt, rd, 5'($urandom), SHIFT_FN[(kind-8)*6 +: 6]};
        else if (kind == 11)
            return {decode_pkg::OP_SPECIAL, rs, 15'd0, decode_pkg::FN_JR};
        else if (kind < 22)
            return {IMM_OP[(kind-12)*6 +: 6], rs, rt, 16'($urandom)};
        else if (kind == 22)
            return {decode_pkg::OP_LUI, 5'd0, rt, 16'($urandom)};
        else if (kind == 23)
            return {($urandom % 2 == 1) ? decode_pkg::OP_JAL : decode_pkg::OP_J, 26'($urandom)};
        return $urandom;
    endfunction

    task automatic drive_inputs(input bit drain);
        fs_valid   = !drain && ($urandom % 10 < 7);
        fs_inst    = random_inst();
        fs_pc      = next_pc;
        es_allowin = drain || ($urandom % 4 != 0);
        es_valid   = !drain && ($urandom % 2 == 1);
        es_gr_we   = ($urandom % 2 == 1);
        es_load    = ($urandom % 4 == 0);
        es_dest    = 5'($urandom % 8);
        es_value   = $urandom;
        ms_valid   = !drain && ($urandom % 2 == 1);
        ms_gr_we   = ($urandom % 2 == 1);
        ms_load    = ($urandom % 4 == 0);
        ms_dest    = 5'($urandom % 8);
        ms_value   = $urandom;
        ws_valid   = ($urandom % 2 == 1);
        ws_gr_we   = ($urandom % 2 == 1);
        ws_dest    = 5'($urandom % 8);
        ws_value   = $urandom;
    endtask

    // compare outputs before the edge, then step the model across it
    task automatic check_cycle();
        ctl_t              c;
        logic              stall;
        logic              exp_to_es;
        logic              exp_allowin;
        decode_pkg::word_t a;
        decode_pkg::word_t b;
        stall       = slot_valid && load_use_hazard(slot_inst);
        exp_to_es   = slot_valid && !stall;
        exp_allowin = !slot_valid || (!stall && es_allowin);
        compare("ds_to_es_valid", 32'(ds_to_es_valid), 32'(exp_to_es));
        compare("ds_allowin", 32'(ds_allowin), 32'(exp_allowin));
        if (exp_to_es) begin
            c = expected_ctl(slot_inst);
            a = forwarded_value(slot_inst[25:21]);
            b = forwarded_value(slot_inst[20:16]);
            compare("ds_alu_op", 32'(ds_alu_op), 32'(c.alu_op));
            compare("{src1_is_sa,src1_is_pc,src2_is_imm,src2_is_8,zero_ext_imm,load,mem_we,gr_we}",
                    32'({ds_src1_is_sa, ds_src1_is_pc, ds_src2_is_imm, ds_src2_is_8,
                         ds_zero_ext_imm, ds_load, ds_mem_we, ds_gr_we}), 32'(c.flags));
            compare("ds_dest", 32'(ds_dest), 32'(c.dest));
            compare("ds_imm", 32'(ds_imm), 32'(slot_inst[15:0]));
            compare("ds_rs_value", ds_rs_value, a);
            compare("ds_rt_value", ds_rt_value, b);
            compare("br_taken", 32'(br_taken), 32'(resolve_taken(c, a, b)));
            if (c.is_branch || c.is_jump_reg || c.is_jump_imm)
                compare("br_target", br_target, jump_target(c, slot_inst, slot_pc, a));
        end else begin
            compare("br_taken", 32'(br_taken), 32'd0);
        end
        // execute takes whatever the DUT offers while allowin is high
        if (ds_to_es_valid === 1'b1 && es_allowin) begin
            if (pc_queue.size() == 0)
                report_error("execute accepted an instruction that fetch never sent");
            else
                compare("ds_pc", ds_pc, pc_queue.pop_front());
        end
        if (fs_valid && exp_allowin) begin
            slot_valid = 1'b1;
            slot_inst  = fs_inst;
            slot_pc    = fs_pc;
            pc_queue.push_back(fs_pc);
            next_pc += 32'd4;
        end else if (exp_to_es && es_allowin) begin
            slot_valid = 1'b0;
        end
        if (ws_valid && ws_gr_we && ws_dest != '0)
            shadow_rf[ws_dest] = ws_value;
    endtask

    task automatic run_cycle(input bit drain);
        @(negedge clk);
        drive_inputs(drain);
        #(CLK_PERIOD / 4);
        check_cycle();
    endtask

    initial begin
        void'($urandom(32'hbaafec79));
        errors     = 0;
        checks     = 0;
        slot_valid = 1'b0;
        slot_inst  = '0;
        slot_pc    = '0;
        next_pc    = 32'hbfc0_0000;
        reset      = 1'b1;
        // the slot registers load a nop while reset holds
        fs_valid   = 1'b1;
        fs_inst    = '0;
        fs_pc      = '0;
        es_allowin = 1'b0;
        {es_valid, es_gr_we, es_load, ms_valid, ms_gr_we, ms_load, ws_valid, ws_gr_we} = '0;
        {es_dest, ms_dest, ws_dest} = '0;
        {es_value, ms_value, ws_value} = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset    = 1'b0;
        fs_valid = 1'b0;
        #(CLK_PERIOD / 4);
        compare("ds_to_es_valid", 32'(ds_to_es_valid), 32'd0);
        compare("br_taken", 32'(br_taken), 32'd0);
        compare("ds_allowin", 32'(ds_allowin), 32'd1);

        // fill every register through writeback so the shadow copy is known
        for (int r = 1; r < 32; r++) begin
            @(negedge clk);
            {ws_valid, ws_gr_we} = 2'b11;
            ws_dest  = 5'(r);
            ws_value = $urandom;
            #(CLK_PERIOD / 4);
            check_cycle();
        end

        for (int n = 0; n < NUM_CYCLES; n++)
            run_cycle(1'b0);

        for (int n = 0; n < DRAIN_LIMIT && pc_queue.size() != 0; n++)
            run_cycle(1'b1);
        if (pc_queue.size() != 0)
            report_error("timed out waiting for execute to accept the fetched instructions");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== id_stage.f ====
+incdir+sim
common/decode_pkg.sv
hdl/regfile.sv
hdl/operand_forward.sv
hdl/stage_control.sv
decode/inst_decoder.sv
decode/branch_resolve.sv
hdl/id_stage.sv
sim/tb_id_stage.sv
